// ==== src/ks10Pkg.sv ====
// Types shared by the instruction front end and its testbench
// Bit 0 is the most significant bit of every word and half word
// Field layouts follow the KS10 instruction format

package ks10Pkg;

   ////////////////////
   // Machine words
   ////////////////////

   // Full 36-bit word, bit 0 is the MSB
   typedef logic [0:35] word_t;

   // Address or half word
   typedef logic [0:17] addr_t;

   // JRST opcode
   localparam logic [0:8] OP_JRST = 9'o254;

   ////////////////////
   // Control word
   ////////////////////

   // IR load select
   typedef enum logic [1:0]
   {
      SPEC_NOP,
      SPEC_LOADIR,
      SPEC_LOADXR,
      SPEC_LOADBOTH
   } specSel_t;

   // Registered control word from the sequencer
   typedef struct packed
   {
      specSel_t specSel;
      logic     eaLoad;
   } crom_t;

   // Sequencer states
   typedef enum logic [2:0]
   {
      S_IDLE,
      S_FETCH,
      S_FETCH_REL,
      S_EA,
      S_IND,
      S_IND_REL,
      S_DISP,
      S_DISP_REL
   } seqState_t;

   ////////////////////
   // Datapath records
   ////////////////////

   // Accumulator write port
   typedef struct packed
   {
      logic       en;
      logic [3:0] addr;
      word_t      data;
   } acWr_t;

   // Record handed to the execution unit
   typedef struct packed
   {
      logic [0:8] opcode;
      logic [0:3] ac;
      addr_t      ea;
      logic       jrst0;
      logic       xrPrev;
   } dispatch_t;

endpackage

// ==== src/regIR.sv ====
// Holds the left half of the current instruction word
// Opcode/AC and I/X halves load independently, both may load together

`timescale 1ns/100ps

module regIR import ks10Pkg::*;
(
   input  logic  clk,
   input  logic  rst,
   input  crom_t crom,
   input  word_t dbus,
   input  logic  pcPrev,
   output addr_t ir,
   output logic  xrPrev,
   output logic  opJrst0
);

   // Load strobes decoded from the control word
   logic       loadIr;
   logic       loadXr;

   // Held opcode and AC fields
   logic [0:8] irOpcode;
   logic [0:3] irAc;

   assign loadIr = (crom.specSel == SPEC_LOADIR) || (crom.specSel == SPEC_LOADBOTH);
   assign loadXr = (crom.specSel == SPEC_LOADXR) || (crom.specSel == SPEC_LOADBOTH);

   ////////////////////
   // IR halves
   ////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         ir     <= '0;
         xrPrev <= 1'b0;
      end
      else
      begin
         // Opcode and AC
         if (loadIr)
         begin
            ir[0:12] <= dbus[0:12];
         end
         // Indirect bit and index, with previous context
         if (loadXr)
         begin
            ir[13:17] <= dbus[13:17];
            xrPrev    <= pcPrev;
         end
      end
   end

   // JRST with AC zero
   assign irOpcode = ir[0:8];
   assign irAc     = ir[9:12];
   assign opJrst0  = (irOpcode == OP_JRST) && (irAc == 4'd0);

endmodule

// ==== src/acFile.sv ====
// Sixteen accumulators, one synchronous write port, one async read port
// AC0 is stored normally, the EA unit ignores it as an index

`timescale 1ns/100ps

module acFile import ks10Pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  acWr_t      acWr,
   input  logic [3:0] xSel,
   output word_t      xData
);

   localparam int NUM_AC = 16;

   // Accumulator storage
   word_t acs [0:NUM_AC-1];

   ////////////////////
   // Write port
   ////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         // All ACs come up zero
         for (int i = 0; i < NUM_AC; i++)
         begin
            acs[i] <= '0;
         end
      end
      else if (acWr.en)
      begin
         // Write from execution side, no handshake
         acs[acWr.addr] <= acWr.data;
      end
   end

   ////////////////////
   // Index read port
   ////////////////////

   // Combinational read, follows xSel directly
   assign xData = acs[xSel];

endmodule

// ==== src/eaCalc.sv ====
// Effective address unit, Y plus right half of AC[X]
// X of zero means no indexing, the sum wraps modulo 2^18
// Result registers only when the control word asks for it

`timescale 1ns/100ps

module eaCalc import ks10Pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  crom_t      crom,
   input  addr_t      ir,
   input  addr_t      y,
   input  word_t      xData,
   output logic [3:0] xSel,
   output addr_t      ea
);

   // Index field of the IR
   logic [3:0] xField;

   // Right half of the index register
   addr_t      xLow;

   // Indexed sum and selected result
   addr_t      sum;
   addr_t      eaNext;

   ////////////////////
   // Index select
   ////////////////////

   // X sits in IR bits 14 to 17
   assign xField = ir[14:17];
   assign xSel   = xField;
   assign xLow   = xData[18:35];

   ////////////////////
   // Adder
   ////////////////////

   // 18-bit add, carry out dropped
   assign sum    = y + xLow;

   // No index when X is zero
   assign eaNext = (xField == 4'd0) ? y : sum;

   // EA register
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         ea <= '0;
      end
      else if (crom.eaLoad)
      begin
         ea <= eaNext;
      end
   end

endmodule

// ==== src/fetchSeq.sv ====
// Fetch sequencer with four-phase memory and dispatch masters
// One instruction in flight, indirect chains have no depth limit
// Control word is registered, derived from the next state

`timescale 1ns/100ps

module fetchSeq import ks10Pkg::*;
#(
   parameter addr_t RESET_VEC = 18'o001000
)
(
   input  logic      clk,
   input  logic      rst,
   output logic      memReq,
   output addr_t     memAddr,
   input  logic      memAck,
   input  word_t     memData,
   input  addr_t     ir,
   input  logic      opJrst0,
   input  logic      xrPrev,
   input  addr_t     ea,
   output crom_t     crom,
   output addr_t     y,
   output logic      dispReq,
   output dispatch_t disp,
   input  logic      dispAck
);

   seqState_t state;
   seqState_t stateNext;
   crom_t     cromNext;

   // Program counter
   addr_t     pc;

   // Indirect bit of the latest word
   logic      indBit;

   // Read cycle of either kind sees its ack
   logic      memDone;

   assign indBit  = ir[13];
   assign memDone = ((state == S_FETCH) || (state == S_IND)) && memAck;

   ////////////////////
   // Next state
   ////////////////////

   always_comb
   begin
      stateNext = state;
      case (state)
         S_IDLE:
            stateNext = S_FETCH;
         S_FETCH:
            if (memAck)
            begin
               stateNext = S_FETCH_REL;
            end
         S_FETCH_REL:
            // Slave must drop ack first
            if (!memAck)
            begin
               stateNext = S_EA;
            end
         S_EA:
            if (indBit)
            begin
               stateNext = S_IND;
            end
            else
            begin
               stateNext = S_DISP;
            end
         S_IND:
            if (memAck)
            begin
               stateNext = S_IND_REL;
            end
         S_IND_REL:
            if (!memAck)
            begin
               stateNext = S_EA;
            end
         S_DISP:
            if (dispAck)
            begin
               stateNext = S_DISP_REL;
            end
         S_DISP_REL:
            if (!dispAck)
            begin
               stateNext = S_FETCH;
            end
         default:
            stateNext = S_IDLE;
      endcase
   end

   // Control word for the coming state
   // IR follows the bus while a read waits, the ack edge leaves the word
   always_comb
   begin
      cromNext = '{specSel: SPEC_NOP, eaLoad: 1'b0};
      case (stateNext)
         S_FETCH: cromNext.specSel = SPEC_LOADBOTH;
         S_IND:   cromNext.specSel = SPEC_LOADXR;
         S_EA:    cromNext.eaLoad  = 1'b1;
         default: cromNext = '{specSel: SPEC_NOP, eaLoad: 1'b0};
      endcase
   end

   ////////////////////
   // State, control word, PC
   ////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state <= S_IDLE;
         crom  <= '{specSel: SPEC_NOP, eaLoad: 1'b0};
         pc    <= RESET_VEC;
      end
      else
      begin
         state <= stateNext;
         crom  <= cromNext;
         // Next PC once dispatch completes
         if ((state == S_DISP_REL) && !dispAck)
         begin
            pc <= disp.jrst0 ? ea : addr_t'(pc + 18'd1);
         end
      end
   end

   // Y half of each word read, first word or indirect
   always_ff @(posedge clk)
   begin
      if (memDone)
      begin
         y <= memData[18:35];
      end
   end

   ////////////////////
   // Handshake outputs
   ////////////////////

   assign memReq  = (state == S_FETCH) || (state == S_IND);
   // Indirect reads go to the current EA
   assign memAddr = ((state == S_IND) || (state == S_IND_REL)) ? ea : pc;
   assign dispReq = (state == S_DISP);

   // Fields hold steady through the whole dispatch exchange
   assign disp = '{opcode: ir[0:8],
                   ac:     ir[9:12],
                   ea:     ea,
                   jrst0:  opJrst0,
                   xrPrev: xrPrev};

endmodule

// ==== src/ifetchTop.sv ====
// Instruction front end top, wiring only
// Memory and dispatch are four-phase, AC writes have no handshake

`timescale 1ns/100ps

module ifetchTop import ks10Pkg::*;
#(
   parameter addr_t RESET_VEC = 18'o001000
)
(
   input  logic      clk,
   input  logic      rst,
   output logic      memReq,
   output addr_t     memAddr,
   input  logic      memAck,
   input  word_t     memData,
   input  logic      pcPrev,
   input  acWr_t     acWr,
   output logic      dispReq,
   output dispatch_t disp,
   input  logic      dispAck
);

   // Control word to the datapath
   crom_t      crom;

   // IR and its decodes
   addr_t      ir;
   logic       xrPrev;
   logic       opJrst0;

   // Index path
   logic [3:0] xSel;
   word_t      xData;

   // Address path
   addr_t      y;
   addr_t      ea;

   ////////////////////
   // Sequencer
   ////////////////////

   fetchSeq #(.RESET_VEC(RESET_VEC)) uFetchSeq
   (
      .clk     (clk),
      .rst     (rst),
      .memReq  (memReq),
      .memAddr (memAddr),
      .memAck  (memAck),
      .memData (memData),
      .ir      (ir),
      .opJrst0 (opJrst0),
      .xrPrev  (xrPrev),
      .ea      (ea),
      .crom    (crom),
      .y       (y),
      .dispReq (dispReq),
      .disp    (disp),
      .dispAck (dispAck)
   );

   ////////////////////
   // Datapath
   ////////////////////

   regIR uRegIR
   (
      .clk     (clk),
      .rst     (rst),
      .crom    (crom),
      .dbus    (memData),
      .pcPrev  (pcPrev),
      .ir      (ir),
      .xrPrev  (xrPrev),
      .opJrst0 (opJrst0)
   );

   acFile uAcFile
   (
      .clk   (clk),
      .rst   (rst),
      .acWr  (acWr),
      .xSel  (xSel),
      .xData (xData)
   );

   eaCalc uEaCalc
   (
      .clk   (clk),
      .rst   (rst),
      .crom  (crom),
      .ir    (ir),
      .y     (y),
      .xData (xData),
      .xSel  (xSel),
      .ea    (ea)
   );

endmodule

// ==== verif/tbMem.sv ====
// Memory model for the fetch unit, slave side of the four-phase read
// Covers all 2^18 words, unwritten words hold a pattern built from the address
// Ack comes 0 to 4 cycles after the request and is driven on the falling edge

`timescale 1ns/100ps

module tbMem import ks10Pkg::*;
(
   input  logic  clk,
   input  logic  rst,
   input  logic  memReq,
   input  addr_t memAddr,
   output logic  memAck,
   output word_t memData
);

   localparam int MEM_WORDS = 1 << 18;

   // Backing store
   word_t mem [0:MEM_WORDS-1];

   // Addresses served, oldest first
   addr_t readLog [$];

   // Preload one word
   task automatic writeWord(input addr_t a, input word_t w);
      mem[a] = w;
   endtask

   // Pop the oldest served address, found is clear when the log is empty
   task automatic takeRead(output addr_t a, output logic found);
      if (readLog.size() > 0)
      begin
         a     = readLog.pop_front();
         found = 1'b1;
      end
      else
      begin
         a     = '0;
         found = 1'b0;
      end
   endtask

   initial
   begin
      int delay;
      // Fill pattern, every address bit shows up in the word
      for (int i = 0; i < MEM_WORDS; i++)
      begin
         mem[i] = {~addr_t'(i), addr_t'(i)};
      end
      memAck  = 1'b0;
      memData = '0;
      forever
      begin
         @(negedge clk);
         if (!rst && memReq && !memAck)
         begin
            // Random ack latency
            delay = $urandom % 5;
            repeat (delay) @(negedge clk);
            memData = mem[memAddr];
            memAck  = 1'b1;
            readLog.push_back(memAddr);
         end
         else if (memAck && !memReq)
         begin
            // Master has let go, close the cycle
            memAck  = 1'b0;
            memData = '0;
         end
      end
   end

endmodule

// ==== verif/ifetchTb.sv ====
// Directed tests for the instruction front end, first fetch at octal 1000
// Dispatch is answered here with random delays, memory comes from tbMem
// All tasks start and end on a falling clock edge

`timescale 1ns/100ps

module ifetchTb import ks10Pkg::*;
();

   localparam addr_t RESET_VEC = 18'o001000;
   localparam int    TIMEOUT   = 200;

   logic      clk;
   logic      rst;
   logic      memReq;
   addr_t     memAddr;
   logic      memAck;
   word_t     memData;
   logic      pcPrev;
   acWr_t     acWr;
   logic      dispReq;
   dispatch_t disp;
   logic      dispAck;

   // Reference state kept by the testbench
   word_t     acModel [0:15];
   addr_t     expPc;
   logic      pending;
   dispatch_t pendingExp;
   int        seedVal;

   ifetchTop #(.RESET_VEC(RESET_VEC)) UUT
   (
      .clk     (clk),
      .rst     (rst),
      .memReq  (memReq),
      .memAddr (memAddr),
      .memAck  (memAck),
      .memData (memData),
      .pcPrev  (pcPrev),
      .acWr    (acWr),
      .dispReq (dispReq),
      .disp    (disp),
      .dispAck (dispAck)
   );

   tbMem memModel
   (
      .clk     (clk),
      .rst     (rst),
      .memReq  (memReq),
      .memAddr (memAddr),
      .memAck  (memAck),
      .memData (memData)
   );

   always #5 clk = ~clk;

   ////////////////////
   // Reporting
   ////////////////////

   task automatic abortRun();
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic reportTimeout(input string what);
      $display("timeout while waiting for %s at %0t", what, $time);
      abortRun();
   endtask

   task automatic checkFlag(input logic got, input logic exp, input string what);
      if (got !== exp)
      begin
         $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
         abortRun();
      end
   endtask

   task automatic checkAddr(input addr_t got, input addr_t exp, input string what);
      if (got !== exp)
      begin
         $display("error at %0t: %s is %o, expected %o", $time, what, got, exp);
         abortRun();
      end
   endtask

   task automatic checkDispatch(input dispatch_t got, input dispatch_t exp, input string what);
      if (got !== exp)
      begin
         $display("error at %0t: %s got op %o ac %o ea %o jrst0 %b xrPrev %b", $time, what,
                  got.opcode, got.ac, got.ea, got.jrst0, got.xrPrev);
         $display("   expected op %o ac %o ea %o jrst0 %b xrPrev %b",
                  exp.opcode, exp.ac, exp.ea, exp.jrst0, exp.xrPrev);
         abortRun();
      end
   endtask

   ////////////////////
   // Reference rules
   ////////////////////

   // Instruction word, opcode in the top nine bits
   function automatic word_t packWord(input logic [0:8] opc, input logic [0:3] acn,
                                      input logic ind, input logic [0:3] x, input addr_t y);
      packWord = {opc, acn, ind, x, y};
   endfunction

   // Y alone for X zero, else Y plus right half of AC[X] mod 2^18
   function automatic addr_t expectEa(input logic [0:3] x, input addr_t y);
      addr_t right;
      right = acModel[x][18:35];
      expectEa = (x == 4'd0) ? y : addr_t'(y + right);
   endfunction

   function automatic logic isJrst0(input logic [0:8] opc, input logic [0:3] acn);
      isJrst0 = (opc == OP_JRST) && (acn == 4'd0);
   endfunction

   // JRST 0 jumps to EA, anything else steps the PC
   function automatic addr_t nextPc(input dispatch_t exp, input addr_t pc);
      nextPc = exp.jrst0 ? exp.ea : addr_t'(pc + 18'd1);
   endfunction

   ////////////////////
   // Handshake helpers
   ////////////////////

   // Write one accumulator, DUT is parked on a dispatch
   task automatic writeAc(input logic [0:3] n, input word_t value);
      acWr = '{en: 1'b1, addr: n, data: value};
      @(negedge clk);
      acWr.en    = 1'b0;
      acModel[n] = value;
   endtask

   // Lets the DUT run on, out of reset or past the parked dispatch
   task automatic resumeDut();
      int delay;
      int cycles;
      if (pending)
      begin
         // Slow ack, record must hold while it waits
         delay = $urandom % 5;
         for (int i = 0; i < delay; i++)
         begin
            @(negedge clk);
            checkFlag(dispReq, 1'b1, "dispReq while held");
            checkDispatch(disp, pendingExp, "held dispatch");
         end
         dispAck = 1'b1;
         cycles  = 0;
         while (dispReq && (cycles < TIMEOUT))
         begin
            @(negedge clk);
            cycles++;
         end
         if (dispReq)
            reportTimeout("dispReq to fall");
         dispAck = 1'b0;
         pending = 1'b0;
      end
      else if (rst)
      begin
         rst = 1'b0;
      end
   endtask

   // Wait for the next dispatch and leave it parked
   task automatic awaitDispatch(input dispatch_t exp);
      int cycles;
      cycles = 0;
      while (!dispReq && (cycles < TIMEOUT))
      begin
         @(negedge clk);
         cycles++;
      end
      if (!dispReq)
         reportTimeout("dispReq to rise");
      checkDispatch(disp, exp, "dispatch record");
      pendingExp = exp;
      pending    = 1'b1;
   endtask

   task automatic checkRead(input addr_t exp);
      addr_t got;
      logic  found;
      memModel.takeRead(got, found);
      if (!found)
      begin
         $display("no memory read was made, one was expected at %o", exp);
         abortRun();
      end
      else
      begin
         checkAddr(got, exp, "read address");
      end
   endtask

   task automatic checkReadsDone();
      addr_t got;
      logic  found;
      memModel.takeRead(got, found);
      if (found)
      begin
         $display("memory was read at %o with no read expected", got);
         abortRun();
      end
   endtask

   ////////////////////
   // Tests
   ////////////////////

   // One instruction with I clear
   task automatic runPlain(input logic [0:8] opc, input logic [0:3] acn, input logic [0:3] x,
                           input addr_t y, input logic prev);
      dispatch_t exp;
      addr_t     pc;
      pc     = expPc;
      pcPrev = prev;
      memModel.writeWord(pc, packWord(opc, acn, 1'b0, x, y));
      exp = '{opcode: opc, ac: acn, ea: expectEa(x, y), jrst0: isJrst0(opc, acn),
              xrPrev: prev};
      resumeDut();
      awaitDispatch(exp);
      checkRead(pc);
      checkReadsDone();
      expPc = nextPc(exp, pc);
   endtask

   // Two pointer levels, the last pointer word gives the final X and Y
   task automatic runIndirect(input logic [0:8] opc, input logic [0:3] acn,
                              input logic [0:3] x0, input addr_t y0,
                              input logic [0:3] x1, input addr_t y1,
                              input logic [0:3] x2, input addr_t y2);
      dispatch_t exp;
      addr_t     pc;
      addr_t     ptr1;
      addr_t     ptr2;
      pc   = expPc;
      ptr1 = expectEa(x0, y0);
      ptr2 = expectEa(x1, y1);
      memModel.writeWord(pc, packWord(opc, acn, 1'b1, x0, y0));
      // Pointer words carry junk opcode and AC
      memModel.writeWord(ptr1, packWord(9'o777, 4'hf, 1'b1, x1, y1));
      memModel.writeWord(ptr2, packWord(9'o525, 4'ha, 1'b0, x2, y2));
      exp = '{opcode: opc, ac: acn, ea: expectEa(x2, y2), jrst0: isJrst0(opc, acn),
              xrPrev: pcPrev};
      resumeDut();
      awaitDispatch(exp);
      checkRead(pc);
      checkRead(ptr1);
      checkRead(ptr2);
      checkReadsDone();
      expPc = nextPc(exp, pc);
   endtask

   // Random fields and index values, every fourth one a JRST 0
   task automatic runRandom(input int count);
      logic [0:8] opc;
      logic [0:3] acn;
      logic [0:3] x;
      addr_t      y;
      for (int n = 0; n < count; n++)
      begin
         opc = 9'($urandom);
         acn = 4'($urandom);
         x   = 4'($urandom);
         y   = 18'($urandom);
         if ((n % 4) == 3)
         begin
            opc = OP_JRST;
            acn = 4'd0;
         end
         writeAc(x, word_t'({$urandom, $urandom}));
         runPlain(opc, acn, x, y, 1'($urandom));
      end
   endtask

   initial
   begin
      seedVal = $urandom(82074);
      clk     = 1'b0;
      rst     = 1'b1;
      pcPrev  = 1'b0;
      acWr    = '0;
      dispAck = 1'b0;
      pending = 1'b0;
      expPc   = RESET_VEC;
      for (int i = 0; i < 16; i++)
      begin
         acModel[i] = '0;
      end
      @(negedge clk);
      checkFlag(memReq, 1'b0, "memReq in reset");
      checkFlag(dispReq, 1'b0, "dispReq in reset");
      @(negedge clk);

      // Direct words in sequence from the reset vector
      runPlain(9'o200, 4'o5, 4'd0, 18'o123456, 1'b0);
      runPlain(9'o270, 4'o17, 4'd0, 18'o000042, 1'b1);
      runPlain(9'o201, 4'o3, 4'd0, 18'o777777, 1'b0);

      // Indexed, then a wrap, then X zero with AC0 loaded
      writeAc(4'd7, 36'o000123_004000);
      runPlain(9'o200, 4'o1, 4'd7, 18'o000100, 1'b0);
      writeAc(4'd12, 36'o777777_000020);
      runPlain(9'o202, 4'o2, 4'd12, 18'o777770, 1'b1);
      writeAc(4'd0, 36'o000000_000500);
      runPlain(9'o200, 4'o4, 4'd0, 18'o000300, 1'b0);

      // Two-level indirect chain with indexing at each level
      pcPrev = 1'b1;
      runIndirect(9'o202, 4'o3, 4'd0, 18'o004000, 4'd7, 18'o001000, 4'd12, 18'o000100);

      // JRST 0 jumps, JRST with an AC steps
      runPlain(OP_JRST, 4'o0, 4'd0, 18'o003000, 1'b0);
      runPlain(9'o200, 4'o2, 4'd0, 18'o000111, 1'b0);
      runPlain(OP_JRST, 4'o5, 4'd0, 18'o006000, 1'b1);
      runPlain(9'o200, 4'o6, 4'd0, 18'o000222, 1'b0);
      runPlain(OP_JRST, 4'o0, 4'd7, 18'o000100, 1'b0);

      // Random delays on both sides, dispatches in program order
      runRandom(16);
      resumeDut();

      $display("Everything OK");
      $finish;
   end

endmodule

// ==== verilog.f ====
src/ks10Pkg.sv
src/regIR.sv
src/acFile.sv
src/eaCalc.sv
src/fetchSeq.sv
src/ifetchTop.sv
verif/tbMem.sv
verif/ifetchTb.sv
